/* source/eth_rx_pkg.sv */
package eth_rx_pkg;

  // preamble plus the start frame delimiter, in bytes.
  localparam int PREAMBLE_LEN = 8;

  // destination, source and ethertype.
  localparam int MAC_HDR_LEN = 14;

  localparam int FCS_LEN = 4;

  // shortest frame on the wire that still carries a whole header and its FCS.
  localparam int MIN_FRAME_LEN = PREAMBLE_LEN + MAC_HDR_LEN + FCS_LEN;

  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;

  // counts the bytes after the start delimiter, FCS included.
  typedef logic [15:0] frame_len_t;

  // reflected form of the IEEE 802.3 polynomial.
  localparam logic [31:0] CRC_POLY = 32'hEDB88320;
  localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

  // register value left after a good frame has been run through together with its FCS.
  localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

  // width of a port index, never below one bit.
  function automatic int port_w(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage : eth_rx_pkg

/* source/crc32.sv */
module crc32 (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic [7:0] dat,
  input  logic       val,
  input  logic       clr,
  output logic       ok
);

  import eth_rx_pkg::*;

  logic [31:0] crc;

  // one byte through the reflected CRC, least significant bit first.
  function automatic logic [31:0] crc_byte(input logic [31:0] c_in, input logic [7:0] d);
    logic [31:0] c;
    c = c_in ^ {24'h0, d};
    for (int b = 0; b < 8; b++) begin
      if (c[0]) begin
        c = (c >> 1) ^ CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      crc <= CRC_INIT;
    end else if (clr) begin
      // the receiver clears at the end of every frame.
      crc <= CRC_INIT;
    end else if (val) begin
      crc <= crc_byte(crc, dat);
    end
  end

  // no final inversion is applied, so a good frame lands on the fixed residue.
  assign ok = (crc == CRC_RESIDUE);

endmodule : crc32

/* source/phy_rx_gate.sv */
module phy_rx_gate #(
  parameter int NUM_PORTS = 4,
  parameter int MIN_IFG   = 12
) (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  logic [7:0]           phy_dat [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] phy_val,
  output logic [7:0]           gated_dat [NUM_PORTS],
  output logic [NUM_PORTS-1:0] gated_val,
  output logic [NUM_PORTS-1:0] gap_drop
);

  localparam int CNT_W = (MIN_IFG > 0) ? $clog2(MIN_IFG + 1) : 1;
  localparam logic [CNT_W-1:0] IFG_MAX = CNT_W'(MIN_IFG);

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    // idle cycles since phy_val last fell, saturating at MIN_IFG.
    logic [CNT_W-1:0] idle_cnt;
    logic             val_q;
    logic             supp;
    logic             rise;
    logic             short_gap;
    logic             block;
    logic             gval_q;
    logic             drop_q;
    logic [7:0]       dat_q;

    assign rise      = phy_val[p] && !val_q;
    assign short_gap = (idle_cnt < IFG_MAX);

    // the decision is taken on the first byte and then held for the whole frame.
    assign block = rise ? short_gap : supp;

    always_ff @(posedge clk) begin
      if (fsm_rst) begin
        idle_cnt <= IFG_MAX;
        val_q    <= 1'b0;
        supp     <= 1'b0;
        gval_q   <= 1'b0;
        drop_q   <= 1'b0;
      end else begin
        val_q  <= phy_val[p];
        gval_q <= phy_val[p] && !block;
        // registered, so the pulse lines up with the first gated byte slot.
        drop_q <= rise && short_gap;
        if (phy_val[p]) begin
          idle_cnt <= '0;
          supp     <= block;
        end else begin
          supp <= 1'b0;
          if (idle_cnt != IFG_MAX) begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
      end
    end

    always_ff @(posedge clk) begin
      dat_q <= phy_dat[p];
    end

    assign gated_dat[p] = dat_q;
    assign gated_val[p] = gval_q;
    assign gap_drop[p]  = drop_q;
  end

endmodule : phy_rx_gate

/* source/mac_rx.sv */
module mac_rx (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic [7:0]             rx_dat,
  input  logic                   rx_val,
  output eth_rx_pkg::mac_addr_t  hdr_dst,
  output eth_rx_pkg::mac_addr_t  hdr_src,
  output eth_rx_pkg::ethertype_t hdr_type,
  output eth_rx_pkg::frame_len_t frame_len,
  output logic                   fcs_ok,
  output logic                   done,
  output logic                   runt
);

  import eth_rx_pkg::*;

  localparam frame_len_t DATA_START = frame_len_t'(PREAMBLE_LEN);
  localparam frame_len_t HDR_END    = frame_len_t'(PREAMBLE_LEN + MAC_HDR_LEN);
  localparam frame_len_t MIN_CNT    = frame_len_t'(MIN_FRAME_LEN);

  // index of the current byte within the frame, preamble included.
  frame_len_t byte_cnt;
  logic       val_q;
  logic       fall;
  logic       long_enough;
  logic       crc_en;
  logic       in_hdr;
  logic       crc_ok;

  // hdr[0] holds the most recent header byte.
  logic [7:0] hdr [MAC_HDR_LEN];

  assign fall        = val_q && !rx_val;
  assign long_enough = (byte_cnt >= MIN_CNT);

  // the CRC covers everything after the start delimiter, FCS included.
  assign crc_en = rx_val && (byte_cnt >= DATA_START);
  assign in_hdr = crc_en && (byte_cnt < HDR_END);

  crc32 u_crc (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .dat     (rx_dat),
    .val     (crc_en),
    .clr     (fall),
    .ok      (crc_ok)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      byte_cnt <= '0;
      val_q    <= 1'b0;
      done     <= 1'b0;
      runt     <= 1'b0;
    end else begin
      val_q <= rx_val;
      // one cycle to see the falling edge and one to register the verdict.
      done  <= fall && long_enough;
      runt  <= fall && !long_enough;
      if (fall) begin
        byte_cnt <= '0;
      end else if (rx_val) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_hdr) begin
      hdr[0] <= rx_dat;
      for (int i = MAC_HDR_LEN - 1; i > 0; i--) begin
        hdr[i] <= hdr[i-1];
      end
    end
  end

  // results only move on a good-length frame, so a runt leaves the last descriptor intact.
  always_ff @(posedge clk) begin
    if (fall && long_enough) begin
      hdr_dst   <= {hdr[13], hdr[12], hdr[11], hdr[10], hdr[9], hdr[8]};
      hdr_src   <= {hdr[7], hdr[6], hdr[5], hdr[4], hdr[3], hdr[2]};
      hdr_type  <= {hdr[1], hdr[0]};
      frame_len <= byte_cnt - DATA_START;
      fcs_ok    <= crc_ok;
    end
  end

endmodule : mac_rx

/* source/rx_desc_arbiter.sv */
module rx_desc_arbiter #(
  parameter int NUM_PORTS = 4
) (
  input  logic                                    clk,
  input  logic                                    fsm_rst,
  input  eth_rx_pkg::mac_addr_t                   hdr_dst [NUM_PORTS],
  input  eth_rx_pkg::mac_addr_t                   hdr_src [NUM_PORTS],
  input  eth_rx_pkg::ethertype_t                  hdr_type [NUM_PORTS],
  input  eth_rx_pkg::frame_len_t                  frame_len [NUM_PORTS],
  input  logic [NUM_PORTS-1:0]                    fcs_ok,
  input  logic [NUM_PORTS-1:0]                    done,
  output logic                                    desc_val,
  output logic [eth_rx_pkg::port_w(NUM_PORTS)-1:0] desc_port,
  output eth_rx_pkg::mac_addr_t                   desc_dst,
  output eth_rx_pkg::mac_addr_t                   desc_src,
  output eth_rx_pkg::ethertype_t                  desc_type,
  output eth_rx_pkg::frame_len_t                  desc_len,
  output logic                                    desc_fcs_ok
);

  import eth_rx_pkg::*;

  localparam int PW = port_w(NUM_PORTS);

  mac_addr_t            hold_dst [NUM_PORTS];
  mac_addr_t            hold_src [NUM_PORTS];
  ethertype_t           hold_type [NUM_PORTS];
  frame_len_t           hold_len [NUM_PORTS];
  logic [NUM_PORTS-1:0] hold_fcs;

  logic [NUM_PORTS-1:0] full;
  logic [NUM_PORTS-1:0] pend;
  logic [PW-1:0]        last;
  logic [PW-1:0]        pick;
  logic                 found;

  // a port that finishes this cycle can be served straight away, which keeps a lone
  // frame at one cycle of latency.
  assign pend = full | done;

  // round robin starting just after the last port served.
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = '0;
    for (int i = 1; i <= NUM_PORTS; i++) begin
      idx = int'(last) + i;
      if (idx >= NUM_PORTS) begin
        idx = idx - NUM_PORTS;
      end
      if (!found && pend[idx]) begin
        found = 1'b1;
        pick  = PW'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      desc_val <= 1'b0;
      full     <= '0;
      last     <= PW'(NUM_PORTS - 1);
    end else begin
      desc_val <= found;
      if (found) begin
        last <= pick;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (found && pick == PW'(p)) begin
          full[p] <= 1'b0;
        end
        // a done that was served directly never occupies the register.
        if (done[p] && !(found && pick == PW'(p) && !full[p])) begin
          full[p] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (done[p]) begin
        hold_dst[p]  <= hdr_dst[p];
        hold_src[p]  <= hdr_src[p];
        hold_type[p] <= hdr_type[p];
        hold_len[p]  <= frame_len[p];
        hold_fcs[p]  <= fcs_ok[p];
      end
    end
    if (found) begin
      desc_port <= pick;
      if (full[pick]) begin
        desc_dst    <= hold_dst[pick];
        desc_src    <= hold_src[pick];
        desc_type   <= hold_type[pick];
        desc_len    <= hold_len[pick];
        desc_fcs_ok <= hold_fcs[pick];
      end else begin
        desc_dst    <= hdr_dst[pick];
        desc_src    <= hdr_src[pick];
        desc_type   <= hdr_type[pick];
        desc_len    <= frame_len[pick];
        desc_fcs_ok <= fcs_ok[pick];
      end
    end
  end

endmodule : rx_desc_arbiter

/* source/eth_rx_multiport.sv */
module eth_rx_multiport #(
  parameter int NUM_PORTS = 4,
  parameter int MIN_IFG   = 12
) (
  input  logic                                    clk,
  input  logic                                    fsm_rst,
  input  logic [7:0]                              phy_dat [NUM_PORTS],
  input  logic [NUM_PORTS-1:0]                    phy_val,
  output logic                                    desc_val,
  output logic [eth_rx_pkg::port_w(NUM_PORTS)-1:0] desc_port,
  output eth_rx_pkg::mac_addr_t                   desc_dst,
  output eth_rx_pkg::mac_addr_t                   desc_src,
  output eth_rx_pkg::ethertype_t                  desc_type,
  output eth_rx_pkg::frame_len_t                  desc_len,
  output logic                                    desc_fcs_ok,
  output logic [NUM_PORTS-1:0]                    gap_drop,
  output logic [NUM_PORTS-1:0]                    runt
);

  import eth_rx_pkg::*;

  logic [7:0]           gated_dat [NUM_PORTS];
  logic [NUM_PORTS-1:0] gated_val;

  mac_addr_t            rx_dst [NUM_PORTS];
  mac_addr_t            rx_src [NUM_PORTS];
  ethertype_t           rx_type [NUM_PORTS];
  frame_len_t           rx_len [NUM_PORTS];
  logic [NUM_PORTS-1:0] rx_fcs_ok;
  logic [NUM_PORTS-1:0] rx_done;

  phy_rx_gate #(
    .NUM_PORTS (NUM_PORTS),
    .MIN_IFG   (MIN_IFG)
  ) u_gate (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .phy_dat   (phy_dat),
    .phy_val   (phy_val),
    .gated_dat (gated_dat),
    .gated_val (gated_val),
    .gap_drop  (gap_drop)
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_rx
    mac_rx u_mac_rx (
      .clk       (clk),
      .fsm_rst   (fsm_rst),
      .rx_dat    (gated_dat[p]),
      .rx_val    (gated_val[p]),
      .hdr_dst   (rx_dst[p]),
      .hdr_src   (rx_src[p]),
      .hdr_type  (rx_type[p]),
      .frame_len (rx_len[p]),
      .fcs_ok    (rx_fcs_ok[p]),
      .done      (rx_done[p]),
      .runt      (runt[p])
    );
  end

  rx_desc_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) u_arb (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .hdr_dst     (rx_dst),
    .hdr_src     (rx_src),
    .hdr_type    (rx_type),
    .frame_len   (rx_len),
    .fcs_ok      (rx_fcs_ok),
    .done        (rx_done),
    .desc_val    (desc_val),
    .desc_port   (desc_port),
    .desc_dst    (desc_dst),
    .desc_src    (desc_src),
    .desc_type   (desc_type),
    .desc_len    (desc_len),
    .desc_fcs_ok (desc_fcs_ok)
  );

endmodule : eth_rx_multiport

/* testbench/rx_checker.sv */
module rx_checker #(
  parameter int NUM_PORTS = 4
) (
  input logic                                    clk,
  input logic                                    fsm_rst,
  input logic                                    desc_val,
  input logic [eth_rx_pkg::port_w(NUM_PORTS)-1:0] desc_port,
  input eth_rx_pkg::mac_addr_t                   desc_dst,
  input eth_rx_pkg::mac_addr_t                   desc_src,
  input eth_rx_pkg::ethertype_t                  desc_type,
  input eth_rx_pkg::frame_len_t                  desc_len,
  input logic                                    desc_fcs_ok,
  input logic [NUM_PORTS-1:0]                    gap_drop,
  input logic [NUM_PORTS-1:0]                    runt
);

  import eth_rx_pkg::*;

  int          cyc;
  int          err_cnt;
  int          chk_cnt;
  int          exp_drop [NUM_PORTS];
  int          exp_runt [NUM_PORTS];

  // expected descriptors, kept as parallel queues in arrival order.
  int          q_port [$];
  logic [47:0] q_dst [$];
  logic [47:0] q_src [$];
  logic [15:0] q_type [$];
  logic [15:0] q_len [$];
  logic        q_fcs [$];
  int          q_end [$];
  int          q_max [$];

  initial begin
    cyc     = 0;
    err_cnt = 0;
    chk_cnt = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      exp_drop[p] = 0;
      exp_runt[p] = 0;
    end
  end

  task automatic expect_desc(input int port, input logic [47:0] dst, input logic [47:0] src,
                             input logic [15:0] typ, input logic [15:0] len,
                             input logic fcs, input int max_lat);
    q_port.push_back(port);
    q_dst.push_back(dst);
    q_src.push_back(src);
    q_type.push_back(typ);
    q_len.push_back(len);
    q_fcs.push_back(fcs);
    q_end.push_back(cyc);
    q_max.push_back(max_lat);
  endtask

  task automatic expect_drop(input int port);
    exp_drop[port]++;
  endtask

  task automatic expect_runt(input int port);
    exp_runt[port]++;
  endtask

  function automatic int pending();
    int n;
    n = q_port.size();
    for (int p = 0; p < NUM_PORTS; p++) begin
      n = n + exp_drop[p] + exp_runt[p];
    end
    return n;
  endfunction

  task automatic check_field(input string name, input logic [47:0] exp, input logic [47:0] got);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED time %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // outputs are sampled half a cycle after the DUT updates them.
  always @(negedge clk) begin
    int idx;
    int lat;
    if (fsm_rst) begin
      check_field("desc_val", 48'd0, {47'd0, desc_val});
      check_field("gap_drop", 48'd0, 48'(gap_drop));
      check_field("runt", 48'd0, 48'(runt));
    end else begin
      if (desc_val === 1'b1) begin
        idx = -1;
        for (int i = 0; i < q_port.size(); i++) begin
          if (idx < 0 && q_port[i] == int'(desc_port)) begin
            idx = i;
          end
        end
        if (idx < 0) begin
          err_cnt++;
          $display("time %0t: descriptor on port %0d that no frame should have produced",
                   $time, desc_port);
        end else begin
          check_field("desc_dst", q_dst[idx], desc_dst);
          check_field("desc_src", q_src[idx], desc_src);
          check_field("desc_type", 48'(q_type[idx]), 48'(desc_type));
          check_field("desc_len", 48'(q_len[idx]), 48'(desc_len));
          check_field("desc_fcs_ok", 48'(q_fcs[idx]), 48'(desc_fcs_ok));
          lat = cyc - q_end[idx];
          chk_cnt++;
          if (lat < 4 || lat > q_max[idx]) begin
            err_cnt++;
            $display("CHECK FAILED time %0t desc_latency expected 4 to %0d got %0d",
                     $time, q_max[idx], lat);
          end
          q_port.delete(idx);
          q_dst.delete(idx);
          q_src.delete(idx);
          q_type.delete(idx);
          q_len.delete(idx);
          q_fcs.delete(idx);
          q_end.delete(idx);
          q_max.delete(idx);
        end
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (gap_drop[p] === 1'b1) begin
          chk_cnt++;
          if (exp_drop[p] > 0) begin
            exp_drop[p]--;
          end else begin
            err_cnt++;
            $display("time %0t: gap_drop pulsed on port %0d without a short gap", $time, p);
          end
        end
        if (runt[p] === 1'b1) begin
          chk_cnt++;
          if (exp_runt[p] > 0) begin
            exp_runt[p]--;
          end else begin
            err_cnt++;
            $display("time %0t: runt pulsed on port %0d for a full-length frame", $time, p);
          end
        end
      end
    end
  end

endmodule : rx_checker

/* testbench/eth_rx_asserts.sv */
module eth_rx_asserts #(
  parameter int NUM_PORTS = 4
) (
  input logic                                    clk,
  input logic                                    fsm_rst,
  input logic                                    desc_val,
  input logic [eth_rx_pkg::port_w(NUM_PORTS)-1:0] desc_port,
  input logic [NUM_PORTS-1:0]                    done,
  input logic [NUM_PORTS-1:0]                    gap_drop,
  input logic [NUM_PORTS-1:0]                    runt
);

  logic seen_done;

  // number of assertion failures so far.
  int   fail_cnt;

  initial begin
    fail_cnt = 0;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      seen_done <= 1'b0;
    end else if (|done) begin
      seen_done <= 1'b1;
    end
  end

  a_desc_after_done: assert property (@(posedge clk) disable iff (fsm_rst)
    desc_val |-> seen_done) else begin
    $error("desc_val before any receiver finished a frame");
    fail_cnt++;
  end

  a_port_range: assert property (@(posedge clk) disable iff (fsm_rst)
    desc_val |-> (!$isunknown(desc_port) && (desc_port < NUM_PORTS))) else begin
    $error("desc_port unknown or out of range");
    fail_cnt++;
  end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_pulse
    a_drop_single: assert property (@(posedge clk) disable iff (fsm_rst)
      gap_drop[p] |=> !gap_drop[p]) else begin
      $error("gap_drop held for two cycles");
      fail_cnt++;
    end
    a_runt_single: assert property (@(posedge clk) disable iff (fsm_rst)
      runt[p] |=> !runt[p]) else begin
      $error("runt held for two cycles");
      fail_cnt++;
    end
  end

endmodule : eth_rx_asserts

bind eth_rx_multiport eth_rx_asserts #(
  .NUM_PORTS (NUM_PORTS)
) u_asserts (
  .clk       (clk),
  .fsm_rst   (fsm_rst),
  .desc_val  (desc_val),
  .desc_port (desc_port),
  .done      (rx_done),
  .gap_drop  (gap_drop),
  .runt      (runt)
);

/* testbench/tb_eth_rx.sv */
module tb_eth_rx;

  import eth_rx_pkg::*;

  localparam int NP       = 4;
  localparam int IFG      = 12;
  localparam int NROWS    = 11;
  localparam int GAP_OK   = 16;
  localparam int RUNT_LEN = 16;

  // one table row drives the same frame shape onto every port in its mask.
  typedef struct packed {
    logic [NP-1:0] mask;
    logic [47:0]   dst;
    logic [47:0]   src;
    logic [15:0]   typ;
    logic [15:0]   pl;
    logic          bad_fcs;
    logic          short_gap;
    logic          trunc;
  } row_t;

  logic                         clk;
  logic                         fsm_rst;
  logic [7:0]                   phy_dat [NP];
  logic [NP-1:0]                phy_val;
  logic                         desc_val;
  logic [port_w(NP)-1:0]        desc_port;
  mac_addr_t                    desc_dst;
  mac_addr_t                    desc_src;
  ethertype_t                   desc_type;
  frame_len_t                   desc_len;
  logic                         desc_fcs_ok;
  logic [NP-1:0]                gap_drop;
  logic [NP-1:0]                runt;

  row_t        tbl [NROWS];
  logic [7:0]  fbuf [NP][256];
  int          flen [NP];
  logic [31:0] rng;
  bit          timed_out;

  eth_rx_multiport #(
    .NUM_PORTS (NP),
    .MIN_IFG   (IFG)
  ) uut (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .phy_dat     (phy_dat),
    .phy_val     (phy_val),
    .desc_val    (desc_val),
    .desc_port   (desc_port),
    .desc_dst    (desc_dst),
    .desc_src    (desc_src),
    .desc_type   (desc_type),
    .desc_len    (desc_len),
    .desc_fcs_ok (desc_fcs_ok),
    .gap_drop    (gap_drop),
    .runt        (runt)
  );

  rx_checker #(
    .NUM_PORTS (NP)
  ) chk (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .desc_val    (desc_val),
    .desc_port   (desc_port),
    .desc_dst    (desc_dst),
    .desc_src    (desc_src),
    .desc_type   (desc_type),
    .desc_len    (desc_len),
    .desc_fcs_ok (desc_fcs_ok),
    .gap_drop    (gap_drop),
    .runt        (runt)
  );

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // the FCS is the inverted reflected CRC-32 of the bytes after the start delimiter.
  function automatic logic [31:0] calc_fcs(input int p, input int n);
    logic [31:0] c;
    c = 32'hFFFFFFFF;
    for (int k = 0; k < n; k++) begin
      c = c ^ {24'h0, fbuf[p][8+k]};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  task automatic build_frame(input int p, input int r);
    row_t        rw;
    logic [47:0] dst;
    logic [47:0] src;
    logic [31:0] fcs;
    int          n;
    rw  = tbl[r];
    dst = rw.dst ^ 48'(p);
    src = rw.src ^ 48'(p);
    for (int i = 0; i < 7; i++) begin
      fbuf[p][i] = 8'h55;
    end
    fbuf[p][7] = 8'hD5;
    for (int k = 0; k < 6; k++) begin
      fbuf[p][8+k]  = dst[47-8*k -: 8];
      fbuf[p][14+k] = src[47-8*k -: 8];
    end
    fbuf[p][20] = rw.typ[15:8];
    fbuf[p][21] = rw.typ[7:0];
    for (int k = 0; k < int'(rw.pl); k++) begin
      rng = xorshift(rng);
      fbuf[p][22+k] = rng[7:0];
    end
    n   = 14 + int'(rw.pl);
    fcs = calc_fcs(p, n);
    if (rw.bad_fcs) begin
      fcs = fcs ^ 32'h0000_0100;
    end
    for (int k = 0; k < 4; k++) begin
      fbuf[p][8+n+k] = fcs[8*k +: 8];
    end
    flen[p] = rw.trunc ? RUNT_LEN : 8 + n + 4;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      phy_val = '0;
    end
  endtask

  // all ports of a row carry frames of one length and therefore end together.
  task automatic drive_frame(input int r, input bit want_desc);
    row_t rw;
    int   len;
    rw  = tbl[r];
    len = 0;
    for (int p = 0; p < NP; p++) begin
      if (rw.mask[p]) begin
        len = flen[p];
      end
    end
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      for (int p = 0; p < NP; p++) begin
        if (rw.mask[p]) begin
          phy_val[p] = 1'b1;
          phy_dat[p] = fbuf[p][i];
          if (want_desc && i == len - 1) begin
            chk.expect_desc(p, rw.dst ^ 48'(p), rw.src ^ 48'(p), rw.typ,
                            16'(14 + int'(rw.pl) + 4), !rw.bad_fcs,
                            3 + $countones(rw.mask));
          end
        end
      end
    end
    @(negedge clk);
    phy_val = '0;
  endtask

  task automatic wait_drain(output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < 300) begin
      @(negedge clk);
      n++;
      if (chk.pending() == 0) begin
        ok = 1'b1;
      end
    end
  endtask

  initial begin
    int errs_before;
    int asrt_before;
    bit ok;
    tbl[0]  = '{4'b0001, 48'h0200_0000_0010, 48'h0A00_0000_0001, 16'h0800, 16'd10, 0, 0, 0};
    tbl[1]  = '{4'b0010, 48'h0200_0000_0020, 48'h0A00_0000_0002, 16'h86DD, 16'd20, 0, 0, 0};
    tbl[2]  = '{4'b0100, 48'hFFFF_FFFF_FFF0, 48'h0A00_0000_0003, 16'h0806, 16'd12, 0, 0, 0};
    tbl[3]  = '{4'b1000, 48'h0100_5E00_0040, 48'h0A00_0000_0004, 16'h88CC, 16'd6, 0, 0, 0};
    tbl[4]  = '{4'b0001, 48'h0200_0000_0050, 48'h0A00_0000_0005, 16'h0800, 16'd16, 1, 0, 0};
    tbl[5]  = '{4'b1111, 48'h0200_0000_0060, 48'h0A00_0000_0006, 16'h0800, 16'd8, 0, 0, 0};
    tbl[6]  = '{4'b0010, 48'h0200_0000_0070, 48'h0A00_0000_0007, 16'h0800, 16'd10, 0, 1, 0};
    tbl[7]  = '{4'b0010, 48'h0200_0000_0080, 48'h0A00_0000_0008, 16'h8100, 16'd9, 0, 0, 0};
    tbl[8]  = '{4'b0100, 48'h0200_0000_0090, 48'h0A00_0000_0009, 16'h0800, 16'd10, 0, 0, 1};
    tbl[9]  = '{4'b0100, 48'h0200_0000_00A0, 48'h0A00_0000_000A, 16'h0800, 16'd5, 0, 0, 0};
    tbl[10] = '{4'b1111, 48'h0200_0000_00B0, 48'h0A00_0000_000B, 16'h0801, 16'd30, 1, 0, 0};

    rng       = 32'h9677;
    timed_out = 1'b0;
    fsm_rst   = 1'b1;
    phy_val   = '0;
    for (int p = 0; p < NP; p++) begin
      phy_dat[p] = 8'h00;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;

    for (int r = 0; r < NROWS && !timed_out; r++) begin
      errs_before = chk.err_cnt;
      asrt_before = uut.u_asserts.fail_cnt;
      idle(GAP_OK);
      for (int p = 0; p < NP; p++) begin
        if (tbl[r].mask[p]) begin
          build_frame(p, r);
          if (tbl[r].trunc) begin
            chk.expect_runt(p);
          end
        end
      end
      drive_frame(r, !tbl[r].trunc);
      // a second copy right behind the first breaks the inter-frame gap.
      if (tbl[r].short_gap) begin
        idle(2);
        for (int p = 0; p < NP; p++) begin
          if (tbl[r].mask[p]) begin
            chk.expect_drop(p);
          end
        end
        drive_frame(r, 1'b0);
      end
      wait_drain(ok);
      if (!ok) begin
        timed_out = 1'b1;
        $display("row %0d: expected descriptors or pulses never arrived", r);
      end
      $display("test %0d ports %b: %s", r, tbl[r].mask,
               (ok && chk.err_cnt == errs_before &&
                uut.u_asserts.fail_cnt == asrt_before) ? "ok" : "errors");
    end

    idle(20);
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d, timeout %0d",
             NROWS, chk.chk_cnt, chk.err_cnt, uut.u_asserts.fail_cnt, timed_out);
    if (chk.err_cnt == 0 && uut.u_asserts.fail_cnt == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_eth_rx

/* filelist.f */
source/eth_rx_pkg.sv
source/crc32.sv
source/phy_rx_gate.sv
source/mac_rx.sv
source/rx_desc_arbiter.sv
source/eth_rx_multiport.sv
testbench/rx_checker.sv
testbench/eth_rx_asserts.sv
testbench/tb_eth_rx.sv
